/* Makefile */
VERILATOR ?= verilator
TOP       ?= icache_tb
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f sources.f --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* bench/icache_sva.sv */
/*
  Protocol assertions for the cache, bound into the top level.
*/
module icache_sva #(
  parameter int num_ways = 4,
  parameter int tag_w    = 22
) (
  input logic                         clk_i,
  input logic                         rst_ni,
  input logic                         busy_i,
  input logic                         fetch_valid_i,
  input logic                         fetch_ready_i,
  input logic                         mem_req_i,
  input logic                         mem_ack_i,
  input logic [31:0]                  mem_addr_i,
  input logic                         cmp_en_i,
  input logic [tag_w-1:0]             tag_i,
  input logic [num_ways-1:0][tag_w:0] tag_rdata_i
);

  logic                flushed_q;
  logic [num_ways-1:0] way_hit;

  // set once the reset sweep has ended
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flushed_q <= 1'b0;
    end else if (!busy_i) begin
      flushed_q <= 1'b1;
    end
  end

  for (genvar w = 0; w < num_ways; w++) begin : gen_hit
    assign way_hit[w] = tag_rdata_i[w][tag_w] && (tag_rdata_i[w][tag_w-1:0] == tag_i);
  end

  // nothing reaches the core during the first sweep
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (!flushed_q && busy_i) |-> (!fetch_valid_i && !fetch_ready_i))
    else $error("fetch port active during reset flush");

  // request and address hold until acknowledged
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_req_i && !mem_ack_i) |=> (mem_req_i && $stable(mem_addr_i)))
    else $error("refill request dropped before ack");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmp_en_i |-> $onehot0(way_hit))
    else $error("more than one way hits");

endmodule

bind icache_top icache_sva #(
  .num_ways (num_ways),
  .tag_w    (tag_w)
) icache_sva_inst (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .busy_i        (busy_o),
  .fetch_valid_i (fetch_valid_o),
  .fetch_ready_i (fetch_ready_o),
  .mem_req_i     (mem_req_o),
  .mem_ack_i     (mem_ack_i),
  .mem_addr_i    (mem_addr_o),
  .cmp_en_i      (cmp_en),
  .tag_i         (cmp_tag),
  .tag_rdata_i   (tag_rdata)
);

/* bench/icache_tb.sv */
/*
  Testbench for the instruction cache. Drives random and directed fetches,
  answers refills from a scrambled memory and checks against a residency model.
*/
module icache_tb import icache_pkg::*; ();

  localparam int num_ways = 4;
  localparam int num_sets = 64;
  localparam int idx_w    = $clog2(num_sets);
  // fetches per test
  localparam int n_basic  = 8;
  localparam int n_random = 400;
  localparam int n_nc     = 6;
  localparam int n_dis    = 12;
  localparam int n_flush  = 16;
  localparam int n_total  = n_basic + n_random + n_nc + n_dis + n_flush + 5 * num_sets;
  // 4 time units per cycle
  localparam longint limit_time = longint'(n_total) * 20 * 4;

  logic   clk_i, rst_ni, en_i, flush_i;
  logic   miss_o, busy_o;
  logic   fetch_req_i, fetch_ready_o, fetch_valid_o;
  addr_t  fetch_addr_i;
  fetch_t fetch_data_o;
  logic   mem_req_o, mem_nc_o, mem_ack_i, mem_rtrn_vld_i;
  addr_t  mem_addr_o;
  line_t  mem_rtrn_data_i;

  // monitor counters, updated at the falling edge
  int     miss_cnt, req_cnt, valid_cnt;
  addr_t  req_addr;
  logic   req_nc;
  fetch_t rd_data;
  // model state
  bit     resident [addr_t];
  bit     en_model;
  addr_t  pool [$];

  icache_top #(
    .num_ways (num_ways),
    .num_sets (num_sets)
  ) icache_top_inst (.*);

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;

  //////////////////// memory image

  // fixed scramble of the word address
  function automatic fetch_t scramble(input addr_t a);
    logic [29:0] wa;
    wa = a[addr_w-1:2];
    return {wa[13:0], wa[29:12]} ^ (fetch_t'(wa) * 32'h2545_f491) ^ 32'h9e37_79b9;
  endfunction

  function automatic line_t make_line(input addr_t base);
    line_t l;
    for (int i = 0; i < words_per_line; i++) begin
      l[i*fetch_w +: fetch_w] = scramble(base + addr_t'(i * 4));
    end
    return l;
  endfunction

  //////////////////// compare tasks

  task automatic check_word(input string name, input fetch_t exp, input fetch_t act);
    if (exp !== act) begin
      $display("** Error %s: expected %h, actual %h", name, exp, act);
      $display("Errors found");
      $fatal(1);
    end
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (exp !== act) begin
      $display("** Error %s: expected %h, actual %h", name, exp, act);
      $display("Errors found");
      $fatal(1);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("** Error %s: expected %b, actual %b", name, exp, act);
      $display("Errors found");
      $fatal(1);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (exp != act) begin
      $display("** Error %s: expected %0d, actual %0d", name, exp, act);
      $display("Errors found");
      $fatal(1);
    end
  endtask

  //////////////////// monitor and memory

  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (miss_o) miss_cnt++;
      if (mem_req_o && mem_ack_i) begin
        req_addr = mem_addr_o;
        req_nc   = mem_nc_o;
        req_cnt++;
      end
      if (fetch_valid_o) begin
        rd_data = fetch_data_o;
        valid_cnt++;
      end
    end
  end

  // ack after 0 to 3 cycles, line returned 1 to 5 cycles after the ack
  initial begin
    int dly;
    addr_t base;
    forever begin
      @(posedge clk_i);
      #1;
      if (rst_ni && mem_req_o) begin
        dly = $urandom_range(3, 0);
        repeat (dly) begin
          @(posedge clk_i);
          #1;
        end
        base = {mem_addr_o[addr_w-1:offset_w], {offset_w{1'b0}}};
        mem_ack_i = 1'b1;
        @(posedge clk_i);
        #1;
        mem_ack_i = 1'b0;
        dly = $urandom_range(5, 1);
        repeat (dly - 1) begin
          @(posedge clk_i);
          #1;
        end
        mem_rtrn_data_i = make_line(base);
        mem_rtrn_vld_i  = 1'b1;
        @(posedge clk_i);
        #1;
        mem_rtrn_vld_i = 1'b0;
      end
    end
  end

  initial begin
    #(limit_time);
    $display("timeout: the cache stopped answering fetches");
    $display("Errors found");
    $fatal(1);
  end

  //////////////////// stimulus helpers

  // one fetch, checked for data, refill request and miss pulse
  task automatic do_fetch(input string name, input addr_t addr);
    int    miss0, req0, val0;
    addr_t line;
    logic  cacheable;
    logic  hit_exp;
    miss0     = miss_cnt;
    req0      = req_cnt;
    val0      = valid_cnt;
    line      = {addr[addr_w-1:offset_w], {offset_w{1'b0}}};
    // upper half of the address map is I/O
    cacheable = en_model && !addr[31];
    hit_exp   = cacheable && resident.exists(line);
    fetch_req_i  = 1'b1;
    fetch_addr_i = addr;
    forever begin
      @(negedge clk_i);
      if (fetch_ready_o) break;
    end
    @(posedge clk_i);
    #1;
    fetch_req_i  = 1'b0;
    fetch_addr_i = addr_t'($urandom);
    // a hit answers in the cycle right after acceptance
    if (hit_exp) begin
      @(negedge clk_i);
      check_flag({name, " hit latency"}, 1'b1, fetch_valid_o);
    end
    wait (valid_cnt != val0);
    @(posedge clk_i);
    #1;
    check_word({name, " data"}, scramble(addr), rd_data);
    if (hit_exp) begin
      check_count({name, " hit requests"}, 0, req_cnt - req0);
      check_count({name, " hit misses"}, 0, miss_cnt - miss0);
    end else begin
      check_count({name, " requests"}, 1, req_cnt - req0);
      check_addr({name, " address"}, cacheable ? line : {addr[addr_w-1:2], 2'b00}, req_addr);
      check_flag({name, " nc"}, !cacheable, req_nc);
      check_count({name, " misses"}, cacheable ? 1 : 0, miss_cnt - miss0);
    end
    if (cacheable) resident[line] = 1'b1;
  endtask

  // busy must last exactly one sweep; starts on a falling edge
  task automatic measure_sweep(input string name);
    int cyc;
    cyc = 0;
    @(negedge clk_i);
    check_flag({name, " busy"}, 1'b1, busy_o);
    while (busy_o) begin
      check_flag({name, " ready"}, 1'b0, fetch_ready_o);
      cyc++;
      @(negedge clk_i);
    end
    check_count({name, " sweep cycles"}, num_sets, cyc);
    @(posedge clk_i);
    #1;
    resident.delete();
  endtask

  //////////////////// tests

  initial begin
    addr_t a;
    logic [21:0] tag;
    void'($urandom(32'h4785));
    rst_ni = 1'b0;
    en_i = 1'b1;
    flush_i = 1'b0;
    fetch_req_i = 1'b0;
    fetch_addr_i = '0;
    mem_ack_i = 1'b0;
    mem_rtrn_vld_i = 1'b0;
    mem_rtrn_data_i = '0;
    en_model = 1'b1;
    repeat (4) begin
      @(negedge clk_i);
      check_flag("reset valid", 1'b0, fetch_valid_o);
      check_flag("reset mem_req", 1'b0, mem_req_o);
      check_flag("reset miss", 1'b0, miss_o);
    end
    @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    measure_sweep("reset flush");

    // miss then hits on every word of the line
    for (int i = 0; i < n_basic; i++) begin
      do_fetch("miss_hit", 32'h0000_1230 + addr_t'((i % words_per_line) * 4));
    end

    // pool of num_ways distinct lines in each of 8 sets
    for (int s = 0; s < 8; s++) begin
      for (int w = 0; w < num_ways; w++) begin
        tag = {1'b0, 18'($urandom), 3'(w)};
        pool.push_back({tag, idx_w'(s + 8), {offset_w{1'b0}}});
      end
    end
    for (int i = 0; i < n_random; i++) begin
      a = pool[$urandom_range(pool.size() - 1, 0)] + addr_t'($urandom_range(3, 0) * 4);
      do_fetch("random", a);
      repeat ($urandom_range(1, 0)) begin
        @(posedge clk_i);
        #1;
      end
    end

    // I/O space never allocates
    for (int i = 0; i < n_nc; i++) begin
      do_fetch("bypass", 32'h8000_0104 + addr_t'((i / 2) * 32'h40));
    end

    // disabled cache, then re-enable with its flush
    en_i = 1'b0;
    en_model = 1'b0;
    @(posedge clk_i);
    #1;
    for (int i = 0; i < n_dis / 2; i++) begin
      do_fetch("disabled", pool[i]);
    end
    en_i = 1'b1;
    en_model = 1'b1;
    @(posedge clk_i);
    #1;
    measure_sweep("enable flush");
    for (int i = 0; i < n_dis / 2; i++) begin
      do_fetch("re-enabled", pool[i] + 32'h4);
    end

    // explicit flush
    for (int i = 0; i < n_flush / 2; i++) begin
      do_fetch("pre flush", pool[i + 8]);
    end
    flush_i = 1'b1;
    @(posedge clk_i);
    #1;
    flush_i = 1'b0;
    @(posedge clk_i);
    #1;
    measure_sweep("flush");
    for (int i = 0; i < n_flush / 2; i++) begin
      do_fetch("post flush", pool[i + 8] + 32'h8);
    end

    $display("No errors");
    $finish;
  end

endmodule

/* sources.f */
src/icache_pkg.sv
src/icache_sram.sv
src/icache_repl.sv
src/icache_lookup.sv
src/icache_ctrl.sv
src/icache_top.sv
bench/icache_sva.sv
bench/icache_tb.sv

/* src/icache_ctrl.sv */
/*
  Cache controller. Runs the flush/idle/read/miss FSM, latches the fetch
  address, issues refills and drives the tag and data arrays of all ways.
*/
module icache_ctrl import icache_pkg::*; #(
  parameter int num_ways = 4,
  parameter int num_sets = 64
) (
  input  logic                                               clk_i,
  input  logic                                               rst_ni,
  input  logic                                               en_i,
  input  logic                                               flush_i,
  input  logic                                               fetch_req_i,
  input  addr_t                                              fetch_addr_i,
  input  logic                                               mem_ack_i,
  input  logic                                               mem_rtrn_vld_i,
  input  logic                                               hit_i,
  input  logic [$clog2(num_ways)-1:0]                        repl_way_i,
  output logic                                               fetch_ready_o,
  output logic                                               fetch_valid_o,
  output logic                                               busy_o,
  output logic                                               miss_o,
  output logic                                               mem_req_o,
  output addr_t                                              mem_addr_o,
  output logic                                               mem_nc_o,
  output logic [num_ways-1:0]                                tag_req_o,
  output logic                                               tag_we_o,
  output logic [$clog2(num_sets)-1:0]                        tag_addr_o,
  output logic [addr_w-$clog2(num_sets)-offset_w:0]          tag_wdata_o,
  output logic [num_ways-1:0]                                data_req_o,
  output logic                                               data_we_o,
  output logic [$clog2(num_sets)-1:0]                        data_addr_o,
  output logic                                               cmp_en_o,
  output logic [addr_w-$clog2(num_sets)-offset_w-1:0]        tag_o,
  output logic [offset_w-1:0]                                offset_o
);

  localparam int idx_w = $clog2(num_sets);
  localparam int tag_w = addr_w - idx_w - offset_w;

  typedef enum logic [1:0] {FLUSH, IDLE, READ, MISS} state_e;

  state_e              state_d, state_q;
  logic                cache_en_d, cache_en_q;
  logic                flush_d, flush_q;
  logic [idx_w-1:0]    flush_cnt_q;
  logic                flush_en;
  logic                flush_done;
  logic                start_flush;
  logic                accept;
  logic                fill;
  logic                nc_d, nc_q;
  logic                cmp_en_d, cmp_en_q;
  logic [num_ways-1:0] repl_oh_q;
  addr_t               addr_q;
  logic [idx_w-1:0]    fetch_idx;
  logic [idx_w-1:0]    idx_q;
  logic [tag_w-1:0]    tag_q;

  //////////////////// address split

  // new requests index the arrays straight from the port
  assign fetch_idx = fetch_addr_i[offset_w +: idx_w];
  assign idx_q     = addr_q[offset_w +: idx_w];
  assign tag_q     = addr_q[addr_w-1 -: tag_w];

  assign tag_o    = tag_q;
  assign offset_o = addr_q[offset_w-1:0];

  // I/O space, or everything while the cache is off
  assign accept   = fetch_ready_o & fetch_req_i;
  assign nc_d     = is_noncacheable(fetch_addr_i) | ~cache_en_q;
  // compare in the next cycle only for cacheable fetches
  assign cmp_en_d = accept & ~nc_d;
  assign cmp_en_o = cmp_en_q;

  // line address for fills, word address for bypass
  assign mem_addr_o = nc_q ? {addr_q[addr_w-1:word_w], {word_w{1'b0}}} :
                             {addr_q[addr_w-1:offset_w], {offset_w{1'b0}}};
  assign mem_nc_o   = nc_q;

  // pending flush, or re-enable after the cache was off
  assign start_flush = flush_q | (en_i & ~cache_en_q);
  assign flush_done  = (flush_cnt_q == idx_w'(num_sets - 1));

  assign busy_o = (state_q != IDLE);

  //////////////////// fsm

  always_comb begin
    state_d       = state_q;
    // turning off takes effect at once, turning on goes through a flush
    cache_en_d    = cache_en_q & en_i;
    flush_d       = flush_q | flush_i;
    flush_en      = 1'b0;
    fill          = 1'b0;
    fetch_ready_o = 1'b0;
    fetch_valid_o = 1'b0;
    mem_req_o     = 1'b0;
    miss_o        = 1'b0;

    unique case (state_q)
      // clear one set per cycle
      FLUSH: begin
        flush_en = 1'b1;
        if (flush_done) begin
          state_d    = IDLE;
          flush_d    = 1'b0;
          cache_en_d = en_i;
        end
      end
      // wait for a fetch
      IDLE: begin
        if (start_flush) begin
          state_d = FLUSH;
        end else begin
          fetch_ready_o = 1'b1;
          if (fetch_req_i) begin
            state_d = READ;
          end
        end
      end
      // arrays are valid now
      // on a hit answer and take the next fetch in the same cycle
      READ: begin
        if (cmp_en_q && hit_i) begin
          fetch_valid_o = 1'b1;
          if (start_flush) begin
            state_d = FLUSH;
          end else begin
            fetch_ready_o = 1'b1;
            state_d       = fetch_req_i ? READ : IDLE;
          end
        end else begin
          // miss or bypass, hold the request until acknowledged
          mem_req_o = 1'b1;
          if (mem_ack_i) begin
            // the perf counter only sees real misses
            miss_o  = ~nc_q;
            state_d = MISS;
          end
        end
      end
      // return strobe is consumed unconditionally
      MISS: begin
        if (mem_rtrn_vld_i) begin
          fetch_valid_o = 1'b1;
          fill          = ~nc_q;
          state_d       = start_flush ? FLUSH : IDLE;
        end
      end
      default: begin
        state_d = FLUSH;
      end
    endcase
  end

  //////////////////// array control

  // flush, lookup and fill never overlap
  assign tag_req_o   = (flush_en || accept) ? '1 : (fill ? repl_oh_q : '0);
  assign tag_we_o    = flush_en | fill;
  assign tag_addr_o  = flush_en ? flush_cnt_q : (fill ? idx_q : fetch_idx);
  // valid bit on top, cleared while flushing
  assign tag_wdata_o = {fill, tag_q};

  assign data_req_o  = accept ? '1 : (fill ? repl_oh_q : '0);
  assign data_we_o   = fill;
  assign data_addr_o = fill ? idx_q : fetch_idx;

  //////////////////// registers

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= FLUSH;
      cache_en_q  <= 1'b0;
      flush_q     <= 1'b0;
      flush_cnt_q <= '0;
      nc_q        <= 1'b0;
      cmp_en_q    <= 1'b0;
      repl_oh_q   <= '0;
    end else begin
      state_q     <= state_d;
      cache_en_q  <= cache_en_d;
      flush_q     <= flush_d;
      cmp_en_q    <= cmp_en_d;
      if (flush_en) begin
        flush_cnt_q <= flush_done ? '0 : flush_cnt_q + 1'b1;
      end
      if (accept) begin
        nc_q <= nc_d;
      end
      // the way read out with the lookup is the one refilled later
      if (cmp_en_q) begin
        repl_oh_q <= {{(num_ways-1){1'b0}}, 1'b1} << repl_way_i;
      end
    end
  end

  // fetch address
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q <= fetch_addr_i;
    end
  end

endmodule

/* src/icache_lookup.sv */
/*
  Tag compare and fetch word selection. Purely combinational from the array
  read ports. With compare off, the word is taken from the refill return.
*/
module icache_lookup import icache_pkg::*; #(
  parameter int num_ways = 4,
  parameter int tag_w    = 22
) (
  input  logic                          cmp_en_i,
  input  logic [tag_w-1:0]              tag_i,
  input  logic [offset_w-1:0]           offset_i,
  // bit tag_w of each entry is its valid bit
  input  logic [num_ways-1:0][tag_w:0]  tag_rdata_i,
  input  line_t [num_ways-1:0]          line_rdata_i,
  input  line_t                         rtrn_data_i,
  output logic                          hit_o,
  output fetch_t                        fetch_data_o
);

  localparam int way_w = $clog2(num_ways);
  localparam int sel_w = $clog2(words_per_line);

  logic [num_ways-1:0] way_hit;
  logic [way_w-1:0]    hit_idx;
  logic [sel_w-1:0]    word_sel;
  line_t               sel_line;

  //////////////////// tag compare

  // a way hits only with its valid bit set
  for (genvar w = 0; w < num_ways; w++) begin : gen_cmp
    assign way_hit[w] = tag_rdata_i[w][tag_w] && (tag_rdata_i[w][tag_w-1:0] == tag_i);
  end

  assign hit_o = |way_hit;

  // lowest hitting way
  // a line is never allocated twice, so at most one bit is set anyway
  always_comb begin
    hit_idx = '0;
    for (int i = num_ways - 1; i >= 0; i--) begin
      if (way_hit[i]) begin
        hit_idx = way_w'(i);
      end
    end
  end

  //////////////////// word select

  // drop the byte offset inside the word
  assign word_sel = offset_i[offset_w-1:word_w];

  // array line on a lookup, refill line on a miss or bypass
  assign sel_line = cmp_en_i ? line_rdata_i[hit_idx] : rtrn_data_i;

  assign fetch_data_o = sel_line[word_sel*fetch_w +: fetch_w];

endmodule

/* src/icache_pkg.sv */
/*
  Shared widths, payload types and the address rule of the instruction cache.
  Every cache module imports this package in its header.
*/
package icache_pkg;

  //////////////////// widths

  // physical address of a fetch
  localparam int addr_w = 32;
  // one instruction word
  localparam int fetch_w = 32;
  // one cache line, moved in a single refill beat
  localparam int line_w = 128;
  // byte offset inside a line
  localparam int offset_w = $clog2(line_w / 8);
  // byte offset inside a fetch word
  localparam int word_w = $clog2(fetch_w / 8);
  // fetch words per line
  localparam int words_per_line = line_w / fetch_w;

  //////////////////// payload types

  typedef logic [addr_w-1:0]  addr_t;
  typedef logic [fetch_w-1:0] fetch_t;
  typedef logic [line_w-1:0]  line_t;

  //////////////////// address map

  // top half of the physical space is I/O
  // fetches there never allocate and go straight to memory
  function automatic logic is_noncacheable(input addr_t addr);
    return addr[addr_w-1];
  endfunction

endpackage

/* src/icache_repl.sv */
/*
  Refill way selection. Picks the lowest invalid way of the set that was read,
  or a pseudo-random way from an LFSR once every way holds a valid line.
*/
module icache_repl #(
  parameter int num_ways = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic [num_ways-1:0]         valid_i,
  input  logic                        advance_i,
  output logic [$clog2(num_ways)-1:0] way_o
);

  localparam int way_w  = $clog2(num_ways);
  // wide enough for up to 8 ways
  localparam int lfsr_w = 8;

  logic [way_w-1:0]  inv_way;
  logic              all_valid;
  logic [lfsr_w-1:0] lfsr_q;
  logic              lfsr_fb;

  //////////////////// first invalid way

  // scan from the top so the lowest index wins
  always_comb begin
    inv_way = '0;
    for (int i = num_ways - 1; i >= 0; i--) begin
      if (!valid_i[i]) begin
        inv_way = way_w'(i);
      end
    end
  end

  assign all_valid = &valid_i;

  // random choice only when nothing is free
  assign way_o = all_valid ? lfsr_q[way_w-1:0] : inv_way;

  //////////////////// lfsr

  // x^8 + x^6 + x^5 + x^4 + 1, maximal length
  assign lfsr_fb = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

  // step once per eviction
  // the valid bits are stable while the refill is written
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= 8'hA5;
    end else if (advance_i && all_valid) begin
      lfsr_q <= {lfsr_q[lfsr_w-2:0], lfsr_fb};
    end
  end

endmodule

/* src/icache_sram.sv */
/*
  Single-port synchronous array with a registered read port.
  The word type is a parameter, so one module holds both tag entries and lines.
*/
module icache_sram #(
  parameter type word_t    = logic,
  parameter int  num_words = 64
) (
  input  logic                         clk_i,
  input  logic                         req_i,
  input  logic                         we_i,
  input  logic [$clog2(num_words)-1:0] addr_i,
  input  word_t                        wdata_i,
  output word_t                        rdata_o
);

  // storage, contents are undefined until written
  word_t mem_q [num_words];

  // one access per cycle
  // a write leaves the read register untouched
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        mem_q[addr_i] <= wdata_i;
      end else begin
        // read data shows up one cycle after the request
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

/* src/icache_top.sv */
/*
  Set-associative instruction cache. Fetch port with request/ready, refill port
  with request/acknowledge and a one-beat line return.
*/
module icache_top import icache_pkg::*; #(
  parameter int num_ways = 4,
  parameter int num_sets = 64
) (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   en_i,
  input  logic   flush_i,
  output logic   miss_o,
  output logic   busy_o,
  input  logic   fetch_req_i,
  input  addr_t  fetch_addr_i,
  output logic   fetch_ready_o,
  output logic   fetch_valid_o,
  output fetch_t fetch_data_o,
  output logic   mem_req_o,
  output addr_t  mem_addr_o,
  output logic   mem_nc_o,
  input  logic   mem_ack_i,
  input  logic   mem_rtrn_vld_i,
  input  line_t  mem_rtrn_data_i
);

  localparam int idx_w = $clog2(num_sets);
  localparam int way_w = $clog2(num_ways);
  localparam int tag_w = addr_w - idx_w - offset_w;

  // one tag array word
  typedef struct packed {
    logic             valid;
    logic [tag_w-1:0] tag;
  } tag_entry_t;

  tag_entry_t [num_ways-1:0] tag_rdata;
  line_t [num_ways-1:0]      line_rdata;
  logic [num_ways-1:0]       tag_valid;
  tag_entry_t                tag_wdata;
  logic [num_ways-1:0]       tag_req;
  logic                      tag_we;
  logic [idx_w-1:0]          tag_addr;
  logic [num_ways-1:0]       data_req;
  logic                      data_we;
  logic [idx_w-1:0]          data_addr;
  logic                      cmp_en;
  logic [tag_w-1:0]          cmp_tag;
  logic [offset_w-1:0]       offset;
  logic                      hit;
  logic [way_w-1:0]          repl_way;

  //////////////////// control

  icache_ctrl #(
    .num_ways (num_ways),
    .num_sets (num_sets)
  ) icache_ctrl_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .en_i           (en_i),
    .flush_i        (flush_i),
    .fetch_req_i    (fetch_req_i),
    .fetch_addr_i   (fetch_addr_i),
    .mem_ack_i      (mem_ack_i),
    .mem_rtrn_vld_i (mem_rtrn_vld_i),
    .hit_i          (hit),
    .repl_way_i     (repl_way),
    .fetch_ready_o  (fetch_ready_o),
    .fetch_valid_o  (fetch_valid_o),
    .busy_o         (busy_o),
    .miss_o         (miss_o),
    .mem_req_o      (mem_req_o),
    .mem_addr_o     (mem_addr_o),
    .mem_nc_o       (mem_nc_o),
    .tag_req_o      (tag_req),
    .tag_we_o       (tag_we),
    .tag_addr_o     (tag_addr),
    .tag_wdata_o    (tag_wdata),
    .data_req_o     (data_req),
    .data_we_o      (data_we),
    .data_addr_o    (data_addr),
    .cmp_en_o       (cmp_en),
    .tag_o          (cmp_tag),
    .offset_o       (offset)
  );

  //////////////////// replacement

  // every refill write is offered as an lfsr step
  icache_repl #(
    .num_ways (num_ways)
  ) icache_repl_inst (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .valid_i   (tag_valid),
    .advance_i (data_we),
    .way_o     (repl_way)
  );

  //////////////////// lookup

  icache_lookup #(
    .num_ways (num_ways),
    .tag_w    (tag_w)
  ) icache_lookup_inst (
    .cmp_en_i     (cmp_en),
    .tag_i        (cmp_tag),
    .offset_i     (offset),
    .tag_rdata_i  (tag_rdata),
    .line_rdata_i (line_rdata),
    .rtrn_data_i  (mem_rtrn_data_i),
    .hit_o        (hit),
    .fetch_data_o (fetch_data_o)
  );

  //////////////////// arrays

  // one tag array and one line array per way
  for (genvar w = 0; w < num_ways; w++) begin : gen_way
    icache_sram #(
      .word_t    (tag_entry_t),
      .num_words (num_sets)
    ) tag_sram_inst (
      .clk_i   (clk_i),
      .req_i   (tag_req[w]),
      .we_i    (tag_we),
      .addr_i  (tag_addr),
      .wdata_i (tag_wdata),
      .rdata_o (tag_rdata[w])
    );

    icache_sram #(
      .word_t    (line_t),
      .num_words (num_sets)
    ) data_sram_inst (
      .clk_i   (clk_i),
      .req_i   (data_req[w]),
      .we_i    (data_we),
      .addr_i  (data_addr),
      .wdata_i (mem_rtrn_data_i),
      .rdata_o (line_rdata[w])
    );

    assign tag_valid[w] = tag_rdata[w].valid;
  end

endmodule
